// File: hw/regbus_consts.svh
`ifndef REGBUS_CONSTS_SVH
`define REGBUS_CONSTS_SVH

// one 32-bit word per slot on the register bus data path
`define REGBUS_DATA_W 32

`define REGBUS_ADDR_W 8     // byte address on the AXI-Lite side

// byte offset bits dropped when turning an address into a register number
`define REGBUS_ADDR_LSB 2

`define REGBUS_REG_BITS 4   // 16 register slots of which only the first five are mapped

`define REGBUS_STRB_W 4     // one strobe per data byte

// fixed value returned by the ID register
`define REGBUS_ID_VALUE 32'h5247_0103

`endif

// File: hw/regbus_pkg.sv
`default_nettype none

package regbus_pkg;

  `include "regbus_consts.svh"

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic [`REGBUS_ADDR_W-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [`REGBUS_DATA_W-1:0] data;
    logic [`REGBUS_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [`REGBUS_ADDR_W-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [`REGBUS_DATA_W-1:0] data;
    axi_resp_e                 resp;
  } axil_r_t;

  // register bus write qualified by wren
  typedef struct packed {
    logic [`REGBUS_REG_BITS-1:0] regno;
    logic [`REGBUS_DATA_W-1:0]   data;
    logic [`REGBUS_STRB_W-1:0]   strb;
  } reg_wr_t;

  typedef struct packed {
    logic [`REGBUS_REG_BITS-1:0] regno;  // qualified by rden
  } reg_rd_t;

  typedef enum logic [`REGBUS_REG_BITS-1:0] {
    REG_ID      = 4'd0,
    REG_SCRATCH = 4'd1,
    REG_CTRL    = 4'd2,
    REG_ISSUE   = 4'd3,
    REG_COUNT   = 4'd4
  } reg_index_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ACCEPT,
    WR_RESP
  } wr_state_e;

  typedef struct packed {
    logic [`REGBUS_DATA_W-1:0] tdata;
    logic                      tlast;
  } stream_beat_t;

endpackage

`default_nettype wire

// File: hw/axil_reg_subordinate.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbus_consts.svh"

module axil_reg_subordinate (
  input  logic                        aximm,
  input  logic                        rst_n,
  input  regbus_pkg::axil_aw_t        aw,
  input  logic                        awvalid,
  output logic                        awready,
  input  regbus_pkg::axil_w_t         w,
  input  logic                        wvalid,
  output logic                        wready,
  output regbus_pkg::axi_resp_e       bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  regbus_pkg::axil_ar_t        ar,
  input  logic                        arvalid,
  output logic                        arready,
  output regbus_pkg::axil_r_t         r,
  output logic                        rvalid,
  input  logic                        rready,
  output logic                        wren,
  output regbus_pkg::reg_wr_t         wr,
  output logic                        rden,
  output regbus_pkg::reg_rd_t         rd,
  input  logic [`REGBUS_DATA_W-1:0]   rdata_in
);
  import regbus_pkg::*;

  localparam int REG_TOP = `REGBUS_ADDR_LSB + `REGBUS_REG_BITS;

  wr_state_e                 wr_state;
  reg_wr_t                   wr_q;
  reg_rd_t                   rd_q;
  logic [`REGBUS_DATA_W-1:0] rdata_q;
  logic                      wr_start;
  logic                      ar_take;

  // addresses above the register window land on slot 15, which nothing decodes
  function automatic logic [`REGBUS_REG_BITS-1:0] to_regno(
    input logic [`REGBUS_ADDR_W-1:0] addr
  );
    logic [`REGBUS_REG_BITS-1:0] regno;
    if (addr[`REGBUS_ADDR_W-1:REG_TOP] != '0) begin
      regno = '1;
    end else begin
      regno = addr[REG_TOP-1:`REGBUS_ADDR_LSB];
    end
    return regno;
  endfunction

  assign wr_start = (wr_state == WR_IDLE) && awvalid && wvalid;

  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE:   if (wr_start) wr_state <= WR_ACCEPT;
        WR_ACCEPT: wr_state <= WR_RESP;  // handshake and register write in one cycle
        WR_RESP:   if (bready) wr_state <= WR_IDLE;
        default:   wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge aximm) begin
    if (wr_start) begin
      wr_q.regno <= to_regno(aw.addr);
      wr_q.data  <= w.data;
      wr_q.strb  <= w.strb;
    end
  end

  assign awready = (wr_state == WR_ACCEPT);
  assign wready  = (wr_state == WR_ACCEPT);
  assign wren    = (wr_state == WR_ACCEPT);
  assign wr      = wr_q;
  assign bvalid  = (wr_state == WR_RESP);
  assign bresp   = OKAY;

  // a new address is only taken once the previous read data has gone out
  assign ar_take = arvalid && !rvalid && !arready;

  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      arready <= 1'b0;
    end else begin
      arready <= ar_take;
    end
  end

  always_ff @(posedge aximm) begin
    if (ar_take) rd_q.regno <= to_regno(ar.addr);
  end

  assign rden = arready && arvalid;
  assign rd   = rd_q;

  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rden) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge aximm) begin
    if (rden) rdata_q <= rdata_in;  // register file mux is combinational
  end

  assign r.data = rdata_q;
  assign r.resp = OKAY;

  // the manager holds both valids through the accept cycle
  a_accept_valid: assert property (@(posedge aximm) disable iff (!rst_n)
    awready |-> awvalid && wvalid);

  a_rvalid_held: assert property (@(posedge aximm) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(r.data));

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbus_consts.svh"

module reg_file (
  input  logic                      aximm,
  input  logic                      rst_n,
  input  logic                      wren,
  input  regbus_pkg::reg_wr_t       wr,
  input  logic                      rden,
  input  regbus_pkg::reg_rd_t       rd,
  input  logic [`REGBUS_DATA_W-1:0] issue_status,
  input  logic                      issued,
  output logic [`REGBUS_DATA_W-1:0] rdata
);
  import regbus_pkg::*;

  logic [`REGBUS_DATA_W-1:0] scratch;
  logic [`REGBUS_DATA_W-1:0] ctrl;
  logic [`REGBUS_DATA_W-1:0] count;
  logic                      wr_scratch;
  logic                      wr_ctrl;

  // bytes with their strobe set take the new data, the rest keep the old value
  function automatic logic [`REGBUS_DATA_W-1:0] merge_bytes(
    input logic [`REGBUS_DATA_W-1:0] old_val,
    input reg_wr_t                   w_in
  );
    logic [`REGBUS_DATA_W-1:0] merged;
    merged = old_val;
    for (int i = 0; i < `REGBUS_STRB_W; i++) begin
      if (w_in.strb[i]) begin
        merged[i*8 +: 8] = w_in.data[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  assign wr_scratch = wren && (wr.regno == REG_SCRATCH);
  assign wr_ctrl    = wren && (wr.regno == REG_CTRL);

  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      scratch <= '0;
    end else if (wr_scratch) begin
      scratch <= merge_bytes(scratch, wr);
    end
  end

  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      ctrl <= '0;
    end else if (wr_ctrl) begin
      ctrl <= merge_bytes(ctrl, wr);
    end
  end

  // counts beats the stream actually took and ignores bus writes to this slot
  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      count <= '0;
    end else if (issued) begin
      count <= count + 1'b1;
    end
  end

  always_comb begin
    rdata = '0;
    if (rden) begin
      case (reg_index_e'(rd.regno))
        REG_ID:      rdata = `REGBUS_ID_VALUE;
        REG_SCRATCH: rdata = scratch;
        REG_CTRL:    rdata = ctrl;
        REG_ISSUE:   rdata = issue_status;  // status word lives in the stream block
        REG_COUNT:   rdata = count;
        default:     rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/stream_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbus_consts.svh"

module stream_issue (
  input  logic                      aximm,
  input  logic                      rst_n,
  input  logic                      wren,
  input  regbus_pkg::reg_wr_t       wr,
  input  logic                      rden,
  input  regbus_pkg::reg_rd_t       rd,
  output regbus_pkg::stream_beat_t  beat,
  output logic                      tvalid,
  input  logic                      tready,
  output logic [`REGBUS_DATA_W-1:0] status,
  output logic                      issued
);
  import regbus_pkg::*;

  logic [`REGBUS_DATA_W-1:0] tdata_q;
  logic                      failed;
  logic                      slot_free;
  logic                      issue_wr;
  logic                      status_rd;

  assign slot_free = !(tvalid && !tready);  // a beat leaving this cycle frees the slot
  assign issue_wr  = wren && (wr.regno == REG_ISSUE);
  assign status_rd = rden && (rd.regno == REG_ISSUE);

  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      tvalid <= 1'b0;
    end else if (issue_wr && slot_free) begin
      tvalid <= 1'b1;
    end else if (tready) begin
      tvalid <= 1'b0;
    end
  end

  always_ff @(posedge aximm) begin
    if (issue_wr && slot_free) tdata_q <= wr.data;
  end

  // a dropped write wins over a status read in the same cycle so the event is not lost
  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      failed <= 1'b0;
    end else if (issue_wr && !slot_free) begin
      failed <= 1'b1;
    end else if (status_rd) begin
      failed <= 1'b0;
    end
  end

  always_ff @(posedge aximm) begin
    if (!rst_n) begin
      issued <= 1'b0;
    end else begin
      issued <= tvalid && tready;
    end
  end

  assign beat.tdata = tdata_q;
  assign beat.tlast = 1'b0;
  assign status     = {{(`REGBUS_DATA_W-2){1'b0}}, failed, slot_free};

  a_beat_stable: assert property (@(posedge aximm) disable iff (!rst_n)
    tvalid && !tready |=> tvalid && $stable(beat));

endmodule

`default_nettype wire

// File: hw/regbus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbus_consts.svh"

module regbus_top (
  input  logic                     aximm,
  input  logic                     rst_n,
  input  regbus_pkg::axil_aw_t     aw,
  input  logic                     awvalid,
  output logic                     awready,
  input  regbus_pkg::axil_w_t      w,
  input  logic                     wvalid,
  output logic                     wready,
  output regbus_pkg::axi_resp_e    bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  regbus_pkg::axil_ar_t     ar,
  input  logic                     arvalid,
  output logic                     arready,
  output regbus_pkg::axil_r_t      r,
  output logic                     rvalid,
  input  logic                     rready,
  output regbus_pkg::stream_beat_t beat,
  output logic                     tvalid,
  input  logic                     tready
);
  import regbus_pkg::*;

  logic                      wren;
  reg_wr_t                   wr;
  logic                      rden;
  reg_rd_t                   rd;
  logic [`REGBUS_DATA_W-1:0] rdata;
  logic [`REGBUS_DATA_W-1:0] issue_status;
  logic                      issued;

  axil_reg_subordinate u_sub (
    .aximm, .rst_n,
    .aw, .awvalid, .awready,
    .w, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .ar, .arvalid, .arready,
    .r, .rvalid, .rready,
    .wren, .wr, .rden, .rd,
    .rdata_in (rdata)
  );

  reg_file u_regs (
    .aximm, .rst_n,
    .wren, .wr, .rden, .rd,
    .issue_status, .issued, .rdata
  );

  // shares the register bus with the register file and decodes only its own slot
  stream_issue u_issue (
    .aximm, .rst_n,
    .wren, .wr, .rden, .rd,
    .beat, .tvalid, .tready,
    .status (issue_status),
    .issued
  );

endmodule

`default_nettype wire

// File: verif/tb_regbus.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbus_consts.svh"

module tb_regbus;
  import regbus_pkg::*;

  localparam int N_RESET_RD = 6;
  localparam int N_RW       = 40;   // write plus read back each
  localparam int N_ISSUE    = 8;
  localparam int N_RANDOM   = 150;
  localparam int NUM_TXN    = N_RESET_RD + 2 * N_RW + N_ISSUE + 1 + 4 + N_RANDOM + 1;

  logic         aximm;
  logic         rst_n;
  axil_aw_t     aw;
  logic         awvalid, awready;
  axil_w_t      w;
  logic         wvalid, wready;
  axi_resp_e    bresp;
  logic         bvalid, bready;
  axil_ar_t     ar;
  logic         arvalid, arready;
  axil_r_t      r;
  logic         rvalid, rready;
  stream_beat_t beat;
  logic         tvalid, tready;

  logic [31:0] m_scratch, m_ctrl, m_count;
  logic        m_pending, m_failed, m_issued_d;
  logic [31:0] exp_beats[$];
  logic [31:0] exp_reads[$];
  int          beats_queued;
  int          seed;
  int          sink_seed;
  int          tready_mode;  // 0 low, 1 high, 2 random

  regbus_top UUT (
    .aximm, .rst_n,
    .aw, .awvalid, .awready,
    .w, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .ar, .arvalid, .arready,
    .r, .rvalid, .rready,
    .beat, .tvalid, .tready
  );

  initial begin
    aximm = 1'b0;
    forever #50 aximm = ~aximm;  // 100 ns period
  end

  task automatic stop_on_failure();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      stop_on_failure();
    end
  endtask

  function automatic logic [31:0] merge_strb(input logic [31:0] old_v, input logic [31:0] new_v,
                                             input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  // expected read data for an aligned byte address taken from the model state before the edge
  function automatic logic [31:0] ref_read(input logic [7:0] addr, input logic slot_free);
    case (addr)
      8'h00:   return `REGBUS_ID_VALUE;
      8'h04:   return m_scratch;
      8'h08:   return m_ctrl;
      8'h0c:   return {30'd0, m_failed, slot_free};
      8'h10:   return m_count;
      default: return 32'd0;
    endcase
  endfunction

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int bstall);
    aw.addr = addr;
    w.data  = data;
    w.strb  = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge aximm);
    while (!awready) @(negedge aximm);
    @(negedge aximm);  // valids stay up through the handshake edge
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge aximm);
    repeat (bstall) @(negedge aximm);
    bready = 1'b1;
    @(negedge aximm);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, input int rstall, output logic [31:0] data);
    ar.addr = addr;
    arvalid = 1'b1;
    @(negedge aximm);
    while (!arready) @(negedge aximm);
    @(negedge aximm);
    arvalid = 1'b0;
    while (!rvalid) @(negedge aximm);
    data = r.data;
    repeat (rstall) @(negedge aximm);
    rready = 1'b1;
    @(negedge aximm);
    rready = 1'b0;
  endtask

  initial begin : stream_sink
    logic [31:0] rnd;
    forever begin
      @(negedge aximm);
      rnd = $random(sink_seed);
      if (tready_mode == 2) tready = rnd[0];
      else tready = (tready_mode == 1);
    end
  end

  // samples values from before each rising edge, so the model sees what the DUT sees
  initial begin : compare_model
    logic free;
    logic wr_hs;
    logic issue_hs;
    forever begin
      @(posedge aximm);
      if (!rst_n) begin
        m_scratch    = '0;
        m_ctrl       = '0;
        m_count      = '0;
        m_pending    = 1'b0;
        m_failed     = 1'b0;
        m_issued_d   = 1'b0;
        beats_queued = 0;
      end else begin
        check_val("tvalid", {31'd0, tvalid}, {31'd0, m_pending});
        free     = !(m_pending && !tready);
        wr_hs    = awvalid && awready && wvalid && wready;
        issue_hs = wr_hs && (aw.addr == 8'h0c);
        if (arvalid && arready) exp_reads.push_back(ref_read(ar.addr, free));
        if (rvalid && rready) begin
          if (exp_reads.size() == 0) begin
            $display("read data returned without an accepted read address");
            stop_on_failure();
          end
          check_val("rdata", r.data, exp_reads.pop_front());
          check_val("rresp", {30'd0, r.resp}, {30'd0, OKAY});
        end
        if (bvalid && bready) check_val("bresp", {30'd0, bresp}, {30'd0, OKAY});
        if (tvalid && tready) begin
          if (exp_beats.size() == 0) begin
            $display("stream beat accepted with no issue write behind it");
            stop_on_failure();
          end
          check_val("tdata", beat.tdata, exp_beats.pop_front());
          check_val("tlast", {31'd0, beat.tlast}, 32'd0);
        end
        if (m_issued_d) m_count = m_count + 32'd1;  // count lags the beat by one cycle
        m_issued_d = m_pending && tready;
        if (wr_hs && aw.addr == 8'h04) m_scratch = merge_strb(m_scratch, w.data, w.strb);
        if (wr_hs && aw.addr == 8'h08) m_ctrl = merge_strb(m_ctrl, w.data, w.strb);
        if (issue_hs && free) begin
          m_pending = 1'b1;
          exp_beats.push_back(w.data);
          beats_queued++;
        end else if (tready) begin
          m_pending = 1'b0;
        end
        if (issue_hs && !free) m_failed = 1'b1;
        else if (arvalid && arready && ar.addr == 8'h0c) m_failed = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(NUM_TXN * 200 * 100);
    $display("watchdog: the tests did not finish within %0d cycles", NUM_TXN * 200);
    stop_on_failure();
  end

  initial begin : main_seq
    logic [31:0] rdv;
    logic [31:0] rnd;
    logic [31:0] data;
    logic [7:0]  addr;
    seed        = 32'had36_2b4f;
    sink_seed   = seed ^ 32'h1234_5678;
    tready_mode = 0;
    rst_n   = 1'b0;
    aw      = '0;
    awvalid = 1'b0;
    w       = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    ar      = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    tready  = 1'b0;
    repeat (2) @(negedge aximm);
    rst_n = 1'b1;
    @(negedge aximm);

    // reset values including two unmapped slots
    axil_read(8'h00, 0, rdv);
    axil_read(8'h04, 1, rdv);
    axil_read(8'h08, 0, rdv);
    axil_read(8'h10, 2, rdv);
    axil_read(8'h20, 0, rdv);
    axil_read(8'h80, 0, rdv);

    for (int i = 0; i < N_RW; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      case (rnd[2:1])
        2'd0:    addr = 8'h04;
        2'd1:    addr = 8'h08;
        2'd2:    addr = 8'h00;
        default: addr = 8'h10;
      endcase
      axil_write(addr, data, rnd[7:4], int'(rnd[9:8]));
      axil_read(addr, int'(rnd[11:10]), rdv);
    end

    tready_mode = 1;
    @(negedge aximm);
    for (int i = 0; i < N_ISSUE; i++) begin
      data = $random(seed);
      axil_write(8'h0c, data, 4'hf, 0);
    end
    axil_read(8'h10, 0, rdv);
    check_val("count", rdv, N_ISSUE);
    check_val("beats_left", 32'(exp_beats.size()), 32'd0);

    // second issue write hits a stalled slot and is dropped
    tready_mode = 0;
    repeat (2) @(negedge aximm);
    axil_write(8'h0c, 32'hcafe_0001, 4'hf, 0);
    axil_write(8'h0c, 32'hcafe_0002, 4'hf, 0);
    axil_read(8'h0c, 0, rdv);
    check_val("issue_status", rdv, 32'h2);
    axil_read(8'h0c, 0, rdv);
    check_val("issue_status", rdv, 32'h0);
    tready_mode = 1;
    repeat (3) @(negedge aximm);
    check_val("beats_left", 32'(exp_beats.size()), 32'd0);

    tready_mode = 2;
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      case (rnd[1:0])
        2'd0, 2'd1: axil_write(8'h0c, data, 4'hf, int'(rnd[5:4]));
        2'd2:       axil_read(8'h0c, int'(rnd[5:4]), rdv);
        default:    axil_read(8'h10, int'(rnd[5:4]), rdv);
      endcase
    end
    tready_mode = 1;
    repeat (4) @(negedge aximm);
    axil_read(8'h10, 0, rdv);
    check_val("count", rdv, beats_queued);
    check_val("beats_left", 32'(exp_beats.size()), 32'd0);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/regbus_pkg.sv
hw/axil_reg_subordinate.sv
hw/reg_file.sv
hw/stream_issue.sv
hw/regbus_top.sv
verif/tb_regbus.sv

// File: run.sh
#!/bin/sh
# compile and run the regbus testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_regbus -f vlog.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_regbus > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "STATUS: FAIL" "$SIM_LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
